//--- compile.f
source/cache_pkg.sv
source/word_fifo.sv
source/cache_lru_policy.sv
source/cache_data_store.sv
source/cache_tag_store.sv
source/cache_controller.sv
source/cache_top.sv
verification/cache_props.sv
verification/cache_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := cache_tb
FILELIST  := compile.f
SIM_BIN   := obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
		echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf obj_dir

//--- verification/cache_tb.sv
`timescale 1ns/100ps

module cache_tb;

	localparam int SETS        = 8;
	localparam int BLOCK_WORDS = 4;
	localparam int AW          = cache_pkg::ADDR_BITS;
	localparam int WW          = cache_pkg::WORD_BITS;
	localparam int TIMEOUT     = 400;	// cycles allowed per wait

	typedef struct {
		string         name;
		logic          rw;		// 1 = store
		logic [AW-1:0] addr;
		logic [WW-1:0] wdata;
		logic          exp_hit;
		logic          exp_wb;	// dirty victim goes out
		logic [WW-1:0] exp_data;	// loads only
	} op_t;

	// DUT inputs start defined
	logic          clock_i      = 1'b0;
	logic          resetn_i     = 1'b0;
	logic          core_req_i   = 1'b0;
	logic          core_rw_i    = 1'b0;
	logic [AW-1:0] core_addr_i  = '0;
	logic [WW-1:0] core_data_i  = '0;
	logic          mem_ready_i  = 1'b1;
	logic          fill_valid_i = 1'b0;
	logic [WW-1:0] fill_data_i  = '0;
	logic          wb_pop_i     = 1'b0;

	logic          core_ready_o, core_done_o, mem_req_o, mem_rw_o;
	logic [WW-1:0] core_rdata_o, wb_data_o;
	logic [AW-1:0] mem_addr_o;
	logic          wb_empty_o, hit_o, miss_o, writeback_o;

	logic [WW-1:0] model_mem [2**AW];	// external memory image
	logic [WW-1:0] shadow    [2**AW];	// expected memory contents
	op_t           ops [$];
	logic [AW-1:0] rd_base, wr_base;
	int            rd_left = 0;	// words still to push
	int            wr_left = 0;	// words still to drain
	int            stall_left = 0;
	logic          ready_next = 1'b1;
	logic          stall_en = 1'b0;
	logic          hung = 1'b0;	// a wait ran out
	integer        seed;
	int            hit_cnt, miss_cnt, wb_cnt;
	int            errors = 0;
	int            tests_run = 0;
	int            tests_failed = 0;

	cache_top #(.SETS(SETS), .BLOCK_WORDS(BLOCK_WORDS)) UUT (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.core_req_i(core_req_i), .core_rw_i(core_rw_i),
		.core_addr_i(core_addr_i), .core_data_i(core_data_i),
		.core_ready_o(core_ready_o), .core_done_o(core_done_o),
		.core_rdata_o(core_rdata_o),
		.mem_ready_i(mem_ready_i), .mem_req_o(mem_req_o),
		.mem_rw_o(mem_rw_o), .mem_addr_o(mem_addr_o),
		.fill_valid_i(fill_valid_i), .fill_data_i(fill_data_i),
		.wb_pop_i(wb_pop_i), .wb_data_o(wb_data_o), .wb_empty_o(wb_empty_o),
		.hit_o(hit_o), .miss_o(miss_o), .writeback_o(writeback_o)
	);

	always #2 clock_i = ~clock_i;	// 4 ns period

	// ------------------------------------------------------------
	// memory model samples mid-cycle and drives after the edge
	// ------------------------------------------------------------
	always @(negedge clock_i) begin
		if (resetn_i) begin
			if (hit_o)
				hit_cnt++;
			if (miss_o)
				miss_cnt++;
			if (writeback_o)
				wb_cnt++;
			if (mem_req_o && mem_rw_o) begin
				wr_base = mem_addr_o;	// block write drains the wb buffer
				wr_left = BLOCK_WORDS;
			end else if (mem_req_o) begin
				rd_base = mem_addr_o;	// block read
				rd_left = BLOCK_WORDS;
			end
		end
		if (stall_left > 0) begin
			ready_next = 1'b0;
			stall_left--;
		end else if (stall_en && ($random(seed) & 3) == 0) begin
			ready_next = 1'b0;
			stall_left = $random(seed) & 3;	// up to three more
		end else begin
			ready_next = 1'b1;
		end
		@(posedge clock_i);
		#1;
		mem_ready_i  = ready_next;
		fill_valid_i = (rd_left > 0);
		if (rd_left > 0) begin
			fill_data_i = model_mem[AW'(rd_base + BLOCK_WORDS - rd_left)];
			rd_left--;
		end
		wb_pop_i = (wr_left > 0) && !wb_empty_o;
		if (wb_pop_i) begin
			model_mem[AW'(wr_base + BLOCK_WORDS - wr_left)] = wb_data_o;	// head word
			wr_left--;
		end
	end

	// ------------------------------------------------------------
	// checks and helpers
	// ------------------------------------------------------------
	task automatic compare(input string what, input logic [WW-1:0] expected,
		input logic [WW-1:0] actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, actual %h", what, expected, actual);
			errors++;
		end
	endtask

	task automatic add_op(input string name, input logic rw, input logic [AW-1:0] addr,
		input logic [WW-1:0] wdata, input logic exp_hit, input logic exp_wb,
		input logic [WW-1:0] exp_data);
		op_t e;
		e.name     = name;
		e.rw       = rw;
		e.addr     = addr;
		e.wdata    = wdata;
		e.exp_hit  = exp_hit;
		e.exp_wb   = exp_wb;
		e.exp_data = exp_data;
		ops.push_back(e);
	endtask

	// hand one request to the core port and wait for its done
	task automatic issue_op(input op_t e, output int cycles);
		cycles = 0;
		while (!core_ready_o && cycles < TIMEOUT) begin
			@(posedge clock_i);
			#1;
			cycles++;
		end
		if (!core_ready_o) begin
			$display("core_ready_o stayed low before test %s", e.name);
			hung = 1'b1;
		end else begin
			core_req_i  = 1'b1;
			core_rw_i   = e.rw;
			core_addr_i = e.addr;
			core_data_i = e.wdata;
			@(posedge clock_i);	// accepted here
			#1;
			core_req_i = 1'b0;
			cycles = 1;
			while (!core_done_o && cycles < TIMEOUT) begin
				@(posedge clock_i);
				#1;
				cycles++;
			end
			if (!core_done_o) begin
				$display("core_done_o never came for test %s", e.name);
				hung = 1'b1;
			end
		end
	endtask

	task automatic run_op(input op_t e);
		int cycles;
		int err_before;
		int hits_before;
		int misses_before;
		int wbs_before;
		err_before    = errors;
		hits_before   = hit_cnt;
		misses_before = miss_cnt;
		wbs_before    = wb_cnt;
		issue_op(e, cycles);
		if (!hung) begin
			if (e.rw) begin
				shadow[e.addr] = e.wdata;
			end else begin
				compare({e.name, " data"}, e.exp_data, core_rdata_o);
				compare({e.name, " shadow"}, shadow[e.addr], core_rdata_o);
			end
			if (e.exp_hit)
				compare({e.name, " latency"}, 1, cycles);
			compare({e.name, " hit count"}, 32'(e.exp_hit), hit_cnt - hits_before);
			compare({e.name, " miss count"}, 32'(!e.exp_hit), miss_cnt - misses_before);
			compare({e.name, " writeback count"}, 32'(e.exp_wb), wb_cnt - wbs_before);
			if (e.exp_wb)	// whole victim line at its block address
				for (int w = 0; w < BLOCK_WORDS; w++)
					compare({e.name, " memory word"}, shadow[AW'(wr_base + w)],
						model_mem[AW'(wr_base + w)]);
		end
		tests_run++;
		if (hung || errors != err_before)
			tests_failed++;
		$display("%-16s %s", e.name, (!hung && errors == err_before) ? "ok" : "FAILED");
	endtask

	// ------------------------------------------------------------
	// operation table
	// ------------------------------------------------------------
	initial begin
		seed = 32'hb6ed7919;
		for (int a = 0; a < 2**AW; a++) begin
			model_mem[AW'(a)] = WW'(a * 3 + 1);
			shadow[AW'(a)]    = WW'(a * 3 + 1);
		end
		// set 1 sees tags 0, 1, 2 and 4
		add_op("load_first",    1'b0, 16'h0004, 32'h0, 1'b0, 1'b0, 32'h0000000d);
		add_op("load_repeat",   1'b0, 16'h0004, 32'h0, 1'b1, 1'b0, 32'h0000000d);
		add_op("store_hit",     1'b1, 16'h0005, 32'hdeadbeef, 1'b1, 1'b0, 32'h0);
		add_op("load_stored",   1'b0, 16'h0005, 32'h0, 1'b1, 1'b0, 32'hdeadbeef);
		add_op("load_neighbor", 1'b0, 16'h0006, 32'h0, 1'b1, 1'b0, 32'h00000013);
		add_op("fill_way1",     1'b0, 16'h0024, 32'h0, 1'b0, 1'b0, 32'h0000006d);
		add_op("touch_way0",    1'b0, 16'h0004, 32'h0, 1'b1, 1'b0, 32'h0000000d);
		add_op("third_tag",     1'b0, 16'h0044, 32'h0, 1'b0, 1'b0, 32'h000000cd);
		add_op("load_kept",     1'b0, 16'h0004, 32'h0, 1'b1, 1'b0, 32'h0000000d);
		add_op("load_evicted",  1'b0, 16'h0024, 32'h0, 1'b0, 1'b0, 32'h0000006d);
		add_op("evict_dirty",   1'b0, 16'h0044, 32'h0, 1'b0, 1'b1, 32'h000000cd);
		add_op("reload_dirty",  1'b0, 16'h0005, 32'h0, 1'b0, 1'b0, 32'hdeadbeef);
		add_op("store_miss",    1'b1, 16'h0086, 32'h12345678, 1'b0, 1'b0, 32'h0);
		add_op("load_allocated", 1'b0, 16'h0086, 32'h0, 1'b1, 1'b0, 32'h12345678);
		add_op("load_alloc_nb", 1'b0, 16'h0087, 32'h0, 1'b1, 1'b0, 32'h00000196);

		repeat (8) @(posedge clock_i);
		#1;
		resetn_i = 1'b1;
		compare("reset core_ready_o", 32'h1, 32'(core_ready_o));
		compare("reset core_done_o", 32'h0, 32'(core_done_o));
		compare("reset mem_req_o", 32'h0, 32'(mem_req_o));
		compare("reset wb_empty_o", 32'h1, 32'(wb_empty_o));
		compare("reset hit_o", 32'h0, 32'(hit_o));
		compare("reset miss_o", 32'h0, 32'(miss_o));
		compare("reset writeback_o", 32'h0, 32'(writeback_o));
		tests_run++;
		if (errors != 0)
			tests_failed++;
		$display("%-16s %s", "after_reset", (errors == 0) ? "ok" : "FAILED");

		for (int i = 0; i < ops.size() && !hung; i++) begin
			stall_en = (i >= 5);	// memory stalls from the first way-1 fill on
			run_op(ops[i]);
		end

		$display("%0d tests run, %0d failed, %0d check errors", tests_run, tests_failed,
			errors);
		if (errors == 0 && !hung)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

//--- verification/cache_props.sv
`timescale 1ns/100ps

module cache_props (
	input logic                   clock_i,
	input logic                   resetn_i,
	input logic                   core_req_i,
	input logic                   core_ready_i,
	input logic                   core_done_i,
	input logic                   mem_req_i,
	input logic                   mem_ready_i,
	input logic                   hit_i,
	input logic                   miss_i,
	input cache_pkg::ctrl_state_t state_i
);

	logic open_q;	// request taken, done still owed

	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			open_q <= 1'b0;
		else if (core_req_i && core_ready_i)
			open_q <= 1'b1;	// new request wins over an old done
		else if (core_done_i)
			open_q <= 1'b0;
	end

	// ------------------------------------------------------------
	// controller rules
	// ------------------------------------------------------------
	a_req_ready: assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_req_i |-> mem_ready_i)
		else $error("mem_req_o raised while memory was not ready");

	a_hit_miss: assert property (@(posedge clock_i) disable iff (!resetn_i)
		!(hit_i && miss_i))
		else $error("hit_o and miss_o high in the same cycle");

	// done only for an accepted request, and only out of lookup
	a_done_open: assert property (@(posedge clock_i) disable iff (!resetn_i)
		core_done_i |-> (open_q && state_i == cache_pkg::ST_LOOKUP))
		else $error("core_done_o without an accepted request");

endmodule

bind cache_controller cache_props u_props (
	.clock_i(clock_i), .resetn_i(resetn_i),
	.core_req_i(core_req_i), .core_ready_i(core_ready_o), .core_done_i(core_done_o),
	.mem_req_i(mem_req_o), .mem_ready_i(mem_ready_i),
	.hit_i(hit_o), .miss_i(miss_o), .state_i(state_q)
);

//--- source/cache_top.sv
`timescale 1ns/100ps

module cache_top #(
	parameter SETS        = 8,
	parameter BLOCK_WORDS = 4,
	localparam OFF_BITS   = $clog2(BLOCK_WORDS),
	localparam IDX_BITS   = $clog2(SETS),
	localparam TAG_BITS   = cache_pkg::ADDR_BITS - IDX_BITS - OFF_BITS
)(
	input  logic                           clock_i,
	input  logic                           resetn_i,
	// core port
	input  logic                           core_req_i,
	input  logic                           core_rw_i,
	input  logic [cache_pkg::ADDR_BITS-1:0] core_addr_i,
	input  logic [cache_pkg::WORD_BITS-1:0] core_data_i,
	output logic                           core_ready_o,
	output logic                           core_done_o,
	output logic [cache_pkg::WORD_BITS-1:0] core_rdata_o,
	// command port
	input  logic                           mem_ready_i,
	output logic                           mem_req_o,
	output logic                           mem_rw_o,
	output logic [cache_pkg::ADDR_BITS-1:0] mem_addr_o,
	// memory side of the buffers
	input  logic                           fill_valid_i,
	input  logic [cache_pkg::WORD_BITS-1:0] fill_data_i,
	input  logic                           wb_pop_i,
	output logic [cache_pkg::WORD_BITS-1:0] wb_data_o,
	output logic                           wb_empty_o,
	// performance pulses
	output logic                           hit_o,
	output logic                           miss_o,
	output logic                           writeback_o
);

	// ------------------------------------------------------------
	// internal nets
	// ------------------------------------------------------------
	logic                            tag_hit, tag_hit_way, victim_valid, victim_way;
	logic [TAG_BITS-1:0]             victim_tag;
	logic [IDX_BITS-1:0]             tag_index;
	logic                            tag_write, tag_way, use_strobe, use_way;
	logic [IDX_BITS+OFF_BITS:0]      data_addr;
	logic                            data_write;
	logic [cache_pkg::WORD_BITS-1:0] data_wdata, data_rdata;
	logic                            fill_empty, fill_pop;
	logic [cache_pkg::WORD_BITS-1:0] fill_word, wb_word;
	logic                            wb_full, wb_push;

	cache_controller #(.SETS(SETS), .BLOCK_WORDS(BLOCK_WORDS)) u_ctrl (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.core_req_i(core_req_i), .core_rw_i(core_rw_i),
		.core_addr_i(core_addr_i), .core_data_i(core_data_i),
		.core_ready_o(core_ready_o), .core_done_o(core_done_o),
		.core_rdata_o(core_rdata_o),
		.tag_hit_i(tag_hit), .tag_hit_way_i(tag_hit_way),
		.victim_tag_i(victim_tag), .victim_valid_i(victim_valid),
		.victim_way_i(victim_way),
		.tag_index_o(tag_index), .tag_write_o(tag_write), .tag_way_o(tag_way),
		.use_strobe_o(use_strobe), .use_way_o(use_way),
		.data_rdata_i(data_rdata), .data_addr_o(data_addr),
		.data_write_o(data_write), .data_wdata_o(data_wdata),
		.fill_empty_i(fill_empty), .fill_data_i(fill_word), .fill_pop_o(fill_pop),
		.wb_full_i(wb_full), .wb_push_o(wb_push), .wb_data_o(wb_word),
		.mem_ready_i(mem_ready_i), .mem_req_o(mem_req_o),
		.mem_rw_o(mem_rw_o), .mem_addr_o(mem_addr_o),
		.hit_o(hit_o), .miss_o(miss_o), .writeback_o(writeback_o)
	);

	// tag comes straight from the held core address
	cache_tag_store #(.SETS(SETS), .BLOCK_WORDS(BLOCK_WORDS)) u_tags (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.index_i(tag_index), .tag_i(core_addr_i[cache_pkg::ADDR_BITS-1 -: TAG_BITS]),
		.write_i(tag_write), .write_way_i(tag_way), .victim_way_i(victim_way),
		.hit_o(tag_hit), .hit_way_o(tag_hit_way),
		.victim_tag_o(victim_tag), .victim_valid_o(victim_valid)
	);

	cache_data_store #(.SETS(SETS), .BLOCK_WORDS(BLOCK_WORDS)) u_data (
		.clock_i(clock_i), .addr_i(data_addr), .write_i(data_write),
		.wdata_i(data_wdata), .rdata_o(data_rdata)
	);

	cache_lru_policy #(.SETS(SETS)) u_lru (
		.clock_i(clock_i), .resetn_i(resetn_i), .index_i(tag_index),
		.use_i(use_strobe), .use_way_i(use_way), .victim_way_o(victim_way)
	);

	// ------------------------------------------------------------
	// line buffers, one block deep each
	// ------------------------------------------------------------
	word_fifo #(.DEPTH(BLOCK_WORDS)) fill_buffer (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.push_i(fill_valid_i), .data_i(fill_data_i), .pop_i(fill_pop),
		.data_o(fill_word), .empty_o(fill_empty), .full_o()	// memory paces itself
	);

	word_fifo #(.DEPTH(BLOCK_WORDS)) wb_buffer (
		.clock_i(clock_i), .resetn_i(resetn_i),
		.push_i(wb_push), .data_i(wb_word), .pop_i(wb_pop_i),
		.data_o(wb_data_o), .empty_o(wb_empty_o), .full_o(wb_full)
	);

endmodule

//--- source/cache_controller.sv
`timescale 1ns/100ps

module cache_controller #(
	parameter SETS        = 8,
	parameter BLOCK_WORDS = 4,
	localparam OFF_BITS   = $clog2(BLOCK_WORDS),
	localparam IDX_BITS   = $clog2(SETS),
	localparam TAG_BITS   = cache_pkg::ADDR_BITS - IDX_BITS - OFF_BITS,
	localparam DADDR_BITS = 1 + IDX_BITS + OFF_BITS
)(
	input  logic                           clock_i,
	input  logic                           resetn_i,

	// core port
	input  logic                           core_req_i,
	input  logic                           core_rw_i,	// 1 = store
	input  logic [cache_pkg::ADDR_BITS-1:0] core_addr_i,	// held until done
	input  logic [cache_pkg::WORD_BITS-1:0] core_data_i,
	output logic                           core_ready_o,
	output logic                           core_done_o,
	output logic [cache_pkg::WORD_BITS-1:0] core_rdata_o,

	// tag store and policy
	input  logic                           tag_hit_i,
	input  logic                           tag_hit_way_i,
	input  logic [TAG_BITS-1:0]            victim_tag_i,
	input  logic                           victim_valid_i,
	input  logic                           victim_way_i,
	output logic [IDX_BITS-1:0]            tag_index_o,
	output logic                           tag_write_o,
	output logic                           tag_way_o,
	output logic                           use_strobe_o,
	output logic                           use_way_o,

	// data store
	input  logic [cache_pkg::WORD_BITS-1:0] data_rdata_i,
	output logic [DADDR_BITS-1:0]          data_addr_o,
	output logic                           data_write_o,
	output logic [cache_pkg::WORD_BITS-1:0] data_wdata_o,

	// fill and writeback buffers
	input  logic                           fill_empty_i,
	input  logic [cache_pkg::WORD_BITS-1:0] fill_data_i,
	output logic                           fill_pop_o,
	input  logic                           wb_full_i,
	output logic                           wb_push_o,
	output logic [cache_pkg::WORD_BITS-1:0] wb_data_o,

	// command port
	input  logic                           mem_ready_i,
	output logic                           mem_req_o,
	output logic                           mem_rw_o,	// 1 = block write
	output logic [cache_pkg::ADDR_BITS-1:0] mem_addr_o,

	// performance pulses
	output logic                           hit_o,
	output logic                           miss_o,
	output logic                           writeback_o
);

	cache_pkg::ctrl_state_t state_q;
	logic                  busy_q;		// request taken, core stalled
	logic                  done_q;
	logic                  rd_vld_q;	// data store output holds word cnt_q
	logic [OFF_BITS-1:0]   cnt_q;		// word transfer counter
	logic [2*SETS-1:0]     dirty_q;		// one per line, indexed {way, set}
	logic                  vway_q;		// victim way of current miss
	logic [TAG_BITS-1:0]   vtag_q;		// victim tag for writeback address

	// request fields
	wire [OFF_BITS-1:0] req_off = core_addr_i[OFF_BITS-1:0];
	wire [IDX_BITS-1:0] req_idx = core_addr_i[OFF_BITS +: IDX_BITS];

	wire accept   = core_req_i && !busy_q;	// busy low implies ST_LOOKUP
	wire lookup   = accept || (busy_q && state_q == cache_pkg::ST_LOOKUP);
	wire last     = &cnt_q;			// BLOCK_WORDS is a power of two
	wire wb_go    = (state_q == cache_pkg::ST_WB_READ) && rd_vld_q && !wb_full_i;
	wire fill_go  = (state_q == cache_pkg::ST_FILL) && !fill_empty_i;
	wire [OFF_BITS-1:0] rd_off = wb_go ? cnt_q + 1'b1 : cnt_q;	// read ahead on push

	// ------------------------------------------------------------
	// combinational outputs
	// ------------------------------------------------------------
	assign core_ready_o = !busy_q;
	assign core_done_o  = done_q;
	assign core_rdata_o = data_rdata_i;	// registered read lands in done cycle

	assign tag_index_o  = req_idx;
	assign tag_write_o  = fill_go && last;	// tag + valid with last fill word
	assign tag_way_o    = vway_q;
	assign use_strobe_o = (lookup && tag_hit_i) || (fill_go && last);
	assign use_way_o    = (state_q == cache_pkg::ST_FILL) ? vway_q : tag_hit_way_i;

	always_comb begin
		case (state_q)
			cache_pkg::ST_WB_READ: data_addr_o = {vway_q, req_idx, rd_off};
			cache_pkg::ST_FILL:    data_addr_o = {vway_q, req_idx, cnt_q};
			default:               data_addr_o = {tag_hit_way_i, req_idx, req_off};
		endcase
	end
	assign data_write_o = (lookup && tag_hit_i && core_rw_i) || fill_go;
	assign data_wdata_o = (state_q == cache_pkg::ST_FILL) ? fill_data_i : core_data_i;

	assign fill_pop_o = fill_go;
	assign wb_push_o  = wb_go;
	assign wb_data_o  = data_rdata_i;

	// requests only while memory is ready
	assign mem_req_o  = mem_ready_i && (state_q == cache_pkg::ST_WB_REQ ||
		state_q == cache_pkg::ST_FILL_REQ);
	assign mem_rw_o   = (state_q == cache_pkg::ST_WB_REQ);
	assign mem_addr_o = mem_rw_o ? {vtag_q, req_idx, {OFF_BITS{1'b0}}}
		: {core_addr_i[cache_pkg::ADDR_BITS-1:OFF_BITS], {OFF_BITS{1'b0}}};

	assign hit_o       = accept && tag_hit_i;
	assign miss_o      = accept && !tag_hit_i;	// retry hit after fill not counted
	assign writeback_o = (state_q == cache_pkg::ST_VICTIM) && victim_valid_i &&
		dirty_q[{victim_way_i, req_idx}];

	// ------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state_q  <= cache_pkg::ST_LOOKUP;
			busy_q   <= 1'b0;
			done_q   <= 1'b0;
			rd_vld_q <= 1'b0;
			cnt_q    <= '0;
			dirty_q  <= '0;
		end else begin
			done_q <= 1'b0;	// one-cycle pulse
			case (state_q)
				cache_pkg::ST_LOOKUP: begin
					if (lookup && tag_hit_i) begin
						done_q <= 1'b1;
						busy_q <= 1'b0;
						if (core_rw_i)
							dirty_q[{tag_hit_way_i, req_idx}] <= 1'b1;
					end else if (lookup) begin
						busy_q  <= 1'b1;	// stall core through the miss
						state_q <= cache_pkg::ST_VICTIM;
					end
				end
				cache_pkg::ST_VICTIM: begin
					rd_vld_q <= 1'b0;
					cnt_q    <= '0;
					// clean or invalid victim skips the writeback
					state_q  <= writeback_o ? cache_pkg::ST_WB_READ
						: cache_pkg::ST_FILL_REQ;
				end
				cache_pkg::ST_WB_READ: begin
					rd_vld_q <= 1'b1;	// first read lands after one cycle
					if (wb_go) begin
						cnt_q <= cnt_q + 1'b1;
						if (last)
							state_q <= cache_pkg::ST_WB_REQ;	// line fully buffered
					end
				end
				cache_pkg::ST_WB_REQ: begin
					if (mem_ready_i)
						state_q <= cache_pkg::ST_FILL_REQ;
				end
				cache_pkg::ST_FILL_REQ: begin
					if (mem_ready_i)
						state_q <= cache_pkg::ST_FILL;
				end
				cache_pkg::ST_FILL: begin
					if (fill_go) begin
						cnt_q <= cnt_q + 1'b1;	// wraps to zero after last word
						if (last) begin
							dirty_q[{vway_q, req_idx}] <= 1'b0;
							state_q <= cache_pkg::ST_LOOKUP;	// retry then hits
						end
					end
				end
				default: state_q <= cache_pkg::ST_LOOKUP;
			endcase
		end
	end

	// victim capture
	always_ff @(posedge clock_i) begin
		if (state_q == cache_pkg::ST_VICTIM) begin
			vway_q <= victim_way_i;
			vtag_q <= victim_tag_i;
		end
	end

endmodule

//--- source/cache_tag_store.sv
`timescale 1ns/100ps

module cache_tag_store #(
	parameter SETS        = 8,
	parameter BLOCK_WORDS = 4,
	localparam IDX_BITS   = $clog2(SETS),
	localparam TAG_BITS   = cache_pkg::ADDR_BITS - IDX_BITS - $clog2(BLOCK_WORDS)
)(
	input  logic                clock_i,
	input  logic                resetn_i,
	input  logic [IDX_BITS-1:0] index_i,
	input  logic [TAG_BITS-1:0] tag_i,
	input  logic                write_i,
	input  logic                write_way_i,
	input  logic                victim_way_i,
	output logic                hit_o,
	output logic                hit_way_o,
	output logic [TAG_BITS-1:0] victim_tag_o,
	output logic                victim_valid_o
);

	logic [TAG_BITS-1:0] tag_q   [2][SETS];
	logic [SETS-1:0]     valid_q [2];

	// compare both ways at once
	wire match0 = valid_q[0][index_i] && (tag_q[0][index_i] == tag_i);
	wire match1 = valid_q[1][index_i] && (tag_q[1][index_i] == tag_i);

	assign hit_o          = match0 || match1;
	assign hit_way_o      = match1;	// way 1 when it matches, else way 0
	assign victim_tag_o   = tag_q[victim_way_i][index_i];
	assign victim_valid_o = valid_q[victim_way_i][index_i];

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			valid_q[0] <= '0;
			valid_q[1] <= '0;
		end else if (write_i) begin
			valid_q[write_way_i][index_i] <= 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (write_i)
			tag_q[write_way_i][index_i] <= tag_i;
	end

endmodule

//--- source/cache_data_store.sv
`timescale 1ns/100ps

module cache_data_store #(
	parameter SETS        = 8,
	parameter BLOCK_WORDS = 4,
	localparam ADDR_BITS  = 1 + $clog2(SETS) + $clog2(BLOCK_WORDS)	// {way, set, word}
)(
	input  logic                           clock_i,
	input  logic [ADDR_BITS-1:0]           addr_i,
	input  logic                           write_i,
	input  logic [cache_pkg::WORD_BITS-1:0] wdata_i,
	output logic [cache_pkg::WORD_BITS-1:0] rdata_o
);

	logic [cache_pkg::WORD_BITS-1:0] mem_q [2*SETS*BLOCK_WORDS];

	// single port, registered read
	always_ff @(posedge clock_i) begin
		if (write_i)
			mem_q[addr_i] <= wdata_i;
		rdata_o <= mem_q[addr_i];	// old data on same-cycle write
	end

endmodule

//--- source/cache_lru_policy.sv
`timescale 1ns/100ps

module cache_lru_policy #(
	parameter SETS      = 8,
	localparam IDX_BITS = $clog2(SETS)
)(
	input  logic                clock_i,
	input  logic                resetn_i,
	input  logic [IDX_BITS-1:0] index_i,
	input  logic                use_i,		// hit or fill done
	input  logic                use_way_i,
	output logic                victim_way_o
);

	// per set, the least recently used way
	logic [SETS-1:0] lru_q;

	assign victim_way_o = lru_q[index_i];

	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			lru_q <= '0;	// all sets start at way 0
		else if (use_i)
			lru_q[index_i] <= ~use_way_i;	// other way becomes lru
	end

endmodule

//--- source/word_fifo.sv
`timescale 1ns/100ps

module word_fifo #(
	parameter DEPTH     = 4,
	localparam PTR_BITS = $clog2(DEPTH)
)(
	input  logic                           clock_i,
	input  logic                           resetn_i,
	input  logic                           push_i,
	input  logic [cache_pkg::WORD_BITS-1:0] data_i,
	input  logic                           pop_i,
	output logic [cache_pkg::WORD_BITS-1:0] data_o,
	output logic                           empty_o,
	output logic                           full_o
);

	logic [cache_pkg::WORD_BITS-1:0] mem_q [DEPTH];
	logic [PTR_BITS:0] wr_ptr_q;	// extra msb tells full from empty
	logic [PTR_BITS:0] rd_ptr_q;

	wire do_push = push_i && !full_o;	// overflow dropped
	wire do_pop  = pop_i && !empty_o;	// underflow dropped

	assign empty_o = (wr_ptr_q == rd_ptr_q);
	assign full_o  = (wr_ptr_q[PTR_BITS] != rd_ptr_q[PTR_BITS]) &&
		(wr_ptr_q[PTR_BITS-1:0] == rd_ptr_q[PTR_BITS-1:0]);
	assign data_o  = mem_q[rd_ptr_q[PTR_BITS-1:0]];	// show-ahead head word

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			if (do_push)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_pop)
				rd_ptr_q <= rd_ptr_q + 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (do_push)
			mem_q[wr_ptr_q[PTR_BITS-1:0]] <= data_i;
	end

endmodule

//--- source/cache_pkg.sv
package cache_pkg;

	// ------------------------------------------------------------
	// datapath widths
	// ------------------------------------------------------------
	localparam int WORD_BITS = 32;	// data word
	localparam int ADDR_BITS = 16;	// word address from the core

	// ------------------------------------------------------------
	// controller states
	// ------------------------------------------------------------
	typedef enum logic [2:0] {
		ST_LOOKUP   = 3'd0,	// tag compare, serve hits
		ST_VICTIM   = 3'd1,	// pick victim, check dirty
		ST_WB_READ  = 3'd2,	// copy victim line into wb buffer
		ST_WB_REQ   = 3'd3,	// issue block write
		ST_FILL_REQ = 3'd4,	// issue block read
		ST_FILL     = 3'd5	// drain fill buffer into data store
	} ctrl_state_t;

endpackage
